//--- rtl/gat_pkg.sv
/*
 * Shared types for the GAT weight path. Holds the element, Wh accumulator
 * and logit half types, plus the structs for a feature beat and a score pair.
 */

package gat_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int data_width  = 8;
  // Wide enough for up to 256 input features
  localparam int acc_width   = 24;
  localparam int score_width = 40;

  // ==========================================================================
  // Scalar types
  // ==========================================================================
  // Weight, coefficient or feature element
  typedef logic signed [data_width-1:0]  data_t;
  // One element of the projected vector Wh
  typedef logic signed [acc_width-1:0]   acc_t;
  // One half of the attention logit
  typedef logic signed [score_width-1:0] score_t;

  // ==========================================================================
  // Structs
  // ==========================================================================
  // Feature stream beat, last marks the final element of a vector
  typedef struct packed {
    data_t value;
    logic  last;
  } feat_beat_t;

  // Source and destination logit halves
  typedef struct packed {
    score_t e_src;
    score_t e_dst;
  } score_pair_t;

endpackage

//--- rtl/bram.sv
/*
 * Simple dual-port RAM with one write port and a registered read port.
 * One instance holds one column of W, addressed by row.
 */
`timescale 1ns/10ps

module bram import gat_pkg::*; #(
  parameter int   DEPTH  = 8,
  localparam int  ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              we,
  input  logic [ADDR_W-1:0] waddr,
  input  data_t             wdata,
  input  logic [ADDR_W-1:0] raddr,
  output data_t             rdata
);

  data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read data appears one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[raddr];
    end
  end

  a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> (waddr < DEPTH));

endmodule

//--- rtl/w_loader.sv
/*
 * Weight loader. Walks the flat weight memory in order while load_en is high,
 * writes each column of W into its own bank and keeps the attention vector
 * in registers. weights_loaded stays high from the end of loading until reset.
 */
`timescale 1ns/10ps

module w_loader import gat_pkg::*; #(
  parameter int   NUM_FEATURE_IN  = 8,
  parameter int   NUM_FEATURE_OUT = 4,
  localparam int  W_COUNT         = NUM_FEATURE_IN * NUM_FEATURE_OUT,
  localparam int  A_COUNT         = 2 * NUM_FEATURE_OUT,
  localparam int  WGT_DEPTH       = W_COUNT + A_COUNT,
  localparam int  WGT_ADDR_W      = $clog2(WGT_DEPTH + 1),
  localparam int  ROW_W           = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 load_en,
  output logic [WGT_ADDR_W-1:0]                wgt_addr,
  input  data_t                                wgt_dout,
  output logic [NUM_FEATURE_OUT-1:0]           bank_we,
  output logic [ROW_W-1:0]                     bank_waddr,
  output data_t                                bank_wdata,
  output data_t [2*NUM_FEATURE_OUT-1:0]        a_vec,
  output logic                                 weights_loaded
);

  localparam int COL_W   = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;
  localparam int A_IDX_W = $clog2(A_COUNT + 1);

  logic                  accept;
  logic                  en_d1;
  logic                  en_d2;
  logic                  in_coef;
  logic [ROW_W-1:0]      row;
  logic [COL_W-1:0]      col;
  logic [A_IDX_W-1:0]    a_idx;
  logic                  coef_we;

  // ==========================================================================
  // Address counter and enable delay line
  // ==========================================================================
  assign accept = load_en && (wgt_addr < WGT_DEPTH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_addr <= '0;
      en_d1    <= 1'b0;
      en_d2    <= 1'b0;
    end else begin
      if (accept) begin
        wgt_addr <= wgt_addr + 1'b1;
      end
      // en_d1 marks valid read data from the weight memory
      en_d1 <= accept;
      en_d2 <= en_d1;
    end
  end

  // ==========================================================================
  // W phase, row and column tracking
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row     <= '0;
      col     <= '0;
      in_coef <= 1'b0;
    end else if (en_d1 && !in_coef) begin
      if (col == NUM_FEATURE_OUT - 1) begin
        col <= '0;
        if (row == NUM_FEATURE_IN - 1) begin
          row     <= '0;
          in_coef <= 1'b1;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Element c of row r lands in bank c at address r
  always_comb begin
    bank_we = '0;
    if (en_d1 && !in_coef) begin
      bank_we[col] = 1'b1;
    end
  end

  assign bank_waddr = row;
  assign bank_wdata = wgt_dout;

  // ==========================================================================
  // Attention coefficients
  // ==========================================================================
  assign coef_we = en_d1 && in_coef && (a_idx < A_COUNT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_idx <= '0;
    end else if (coef_we) begin
      a_idx <= a_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (coef_we) begin
      a_vec[a_idx] <= wgt_dout;
    end
  end

  // Rises once the final coefficient has been captured
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weights_loaded <= 1'b0;
    end else if (en_d2 && (a_idx == A_COUNT)) begin
      weights_loaded <= 1'b1;
    end
  end

  a_no_write_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    weights_loaded |-> (bank_we == '0));

endmodule

//--- rtl/wh_engine.sv
/*
 * Projection engine. Each feature beat reads one row of W from all banks,
 * multiplies it by the feature value and accumulates the result into Wh.
 * wh_valid pulses with the finished vector two cycles after the last beat.
 */
`timescale 1ns/10ps

module wh_engine import gat_pkg::*; #(
  parameter int   NUM_FEATURE_IN  = 8,
  parameter int   NUM_FEATURE_OUT = 4,
  localparam int  ROW_W           = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           weights_loaded,
  input  logic                           feat_valid,
  input  feat_beat_t                     feat,
  output logic [ROW_W-1:0]               bank_raddr,
  input  data_t [NUM_FEATURE_OUT-1:0]    bank_rdata,
  output logic                           wh_valid,
  output acc_t [NUM_FEATURE_OUT-1:0]     wh
);

  localparam int CNT_W = $clog2(NUM_FEATURE_IN + 1);

  logic                          take;
  logic [CNT_W-1:0]              row_cnt;
  logic                          s1_valid;
  logic                          s1_first;
  logic                          s1_last;
  data_t                         s1_value;
  logic                          s2_valid;
  logic                          s2_first;
  logic                          s2_last;
  acc_t [NUM_FEATURE_OUT-1:0]    prod;
  acc_t [NUM_FEATURE_OUT-1:0]    acc;
  acc_t [NUM_FEATURE_OUT-1:0]    acc_next;

  assign take       = feat_valid && weights_loaded;
  assign bank_raddr = row_cnt[ROW_W-1:0];

  // Row of W for the current beat, back to zero after the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_cnt <= '0;
    end else if (take) begin
      row_cnt <= feat.last ? '0 : row_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // Stage 1, align the beat with the bank read latency
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_first <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= take;
      s1_first <= take && (row_cnt == '0);
      s1_last  <= take && feat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      s1_value <= feat.value;
    end
  end

  // ==========================================================================
  // Stage 2, multiply, then accumulate
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
      s2_first <= 1'b0;
      s2_last  <= 1'b0;
      wh_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
      s2_first <= s1_first;
      s2_last  <= s1_last;
      wh_valid <= s2_valid && s2_last;
    end
  end

  // Signed 8x8 products, widened to the accumulator
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        prod[c] <= bank_rdata[c] * s1_value;
      end
    end
  end

  // First beat of a vector restarts the sum
  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      acc_next[c] = s2_first ? prod[c] : acc[c] + prod[c];
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      acc <= acc_next;
    end
    if (s2_valid && s2_last) begin
      wh <= acc_next;
    end
  end

  a_beat_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    feat_valid |-> weights_loaded);

  a_row_bound: assert property (@(posedge clk) disable iff (!rst_n)
    take |-> (row_cnt < NUM_FEATURE_IN));

endmodule

//--- rtl/attn_score.sv
/*
 * Score unit. Forms the source and destination halves of the attention
 * logit as dot products of Wh with the two halves of a, in one registered
 * stage. Results and the matching Wh are held until the next vector.
 */
`timescale 1ns/10ps

module attn_score import gat_pkg::*; #(
  parameter int NUM_FEATURE_IN  = 8,
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            wh_valid,
  input  acc_t [NUM_FEATURE_OUT-1:0]      wh,
  input  data_t [2*NUM_FEATURE_OUT-1:0]   a_vec,
  output logic                            out_valid,
  output score_pair_t                     scores,
  output acc_t [NUM_FEATURE_OUT-1:0]      wh_out
);

  // Bound on one term times F, checked against the logit width
  localparam int TERM_W = data_width + acc_width;
  localparam int SUM_W  = TERM_W + $clog2(NUM_FEATURE_OUT + 1);

  score_t src_sum;
  score_t dst_sum;

  // ==========================================================================
  // Dot products over F terms
  // ==========================================================================
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      src_sum = src_sum + score_t'(a_vec[c]) * score_t'(wh[c]);
      dst_sum = dst_sum + score_t'(a_vec[NUM_FEATURE_OUT + c]) * score_t'(wh[c]);
    end
  end

  // ==========================================================================
  // Output register
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= wh_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_valid) begin
      scores.e_src <= src_sum;
      scores.e_dst <= dst_sum;
      wh_out       <= wh;
    end
  end

  // Elaboration check that the logit halves cannot overflow
  initial begin
    if (SUM_W > score_width) begin
      $error("score_t too narrow for %0d output features", NUM_FEATURE_OUT);
    end
    if (NUM_FEATURE_IN > 256) begin
      $error("acc_t too narrow for %0d input features", NUM_FEATURE_IN);
    end
  end

endmodule

//--- rtl/gat_wh_top.sv
/*
 * Weight path top level. Connects the weight loader, one column bank per
 * output feature, the projection engine and the score unit.
 */
`timescale 1ns/10ps

module gat_wh_top import gat_pkg::*; #(
  parameter int   NUM_FEATURE_IN  = 8,
  parameter int   NUM_FEATURE_OUT = 4,
  localparam int  WGT_DEPTH       = (NUM_FEATURE_IN + 2) * NUM_FEATURE_OUT,
  localparam int  WGT_ADDR_W      = $clog2(WGT_DEPTH + 1),
  localparam int  ROW_W           = (NUM_FEATURE_IN > 1) ? $clog2(NUM_FEATURE_IN) : 1
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_en,
  output logic [WGT_ADDR_W-1:0]         wgt_addr,
  input  data_t                         wgt_dout,
  output logic                          weights_loaded,
  input  logic                          feat_valid,
  input  feat_beat_t                    feat,
  output logic                          out_valid,
  output score_pair_t                   scores,
  output acc_t [NUM_FEATURE_OUT-1:0]    wh_out
);

  logic [NUM_FEATURE_OUT-1:0]           bank_we;
  logic [ROW_W-1:0]                     bank_waddr;
  data_t                                bank_wdata;
  logic [ROW_W-1:0]                     bank_raddr;
  data_t [NUM_FEATURE_OUT-1:0]          bank_rdata;
  data_t [2*NUM_FEATURE_OUT-1:0]        a_vec;
  logic                                 wh_valid;
  acc_t [NUM_FEATURE_OUT-1:0]           wh;

  w_loader #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) i_w_loader (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_en        (load_en),
    .wgt_addr       (wgt_addr),
    .wgt_dout       (wgt_dout),
    .bank_we        (bank_we),
    .bank_waddr     (bank_waddr),
    .bank_wdata     (bank_wdata),
    .a_vec          (a_vec),
    .weights_loaded (weights_loaded)
  );

  // One bank per column of W
  for (genvar c = 0; c < NUM_FEATURE_OUT; c++) begin : g_bank
    bram #(
      .DEPTH (NUM_FEATURE_IN)
    ) i_bram (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (bank_we[c]),
      .waddr (bank_waddr),
      .wdata (bank_wdata),
      .raddr (bank_raddr),
      .rdata (bank_rdata[c])
    );
  end

  wh_engine #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) i_wh_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .weights_loaded (weights_loaded),
    .feat_valid     (feat_valid),
    .feat           (feat),
    .bank_raddr     (bank_raddr),
    .bank_rdata     (bank_rdata),
    .wh_valid       (wh_valid),
    .wh             (wh)
  );

  attn_score #(
    .NUM_FEATURE_IN  (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT)
  ) i_attn_score (
    .clk       (clk),
    .rst_n     (rst_n),
    .wh_valid  (wh_valid),
    .wh        (wh),
    .a_vec     (a_vec),
    .out_valid (out_valid),
    .scores    (scores),
    .wh_out    (wh_out)
  );

endmodule

//--- tb/tb_gat_wh.sv
/*
 * Testbench for the GAT weight path. Models the external weight memory,
 * loads it with random pauses, streams random feature vectors and checks
 * load timing, Wh and both logit halves with concurrent assertions.
 */
`timescale 1ns/10ps

module tb_gat_wh import gat_pkg::*;;

  localparam int NI         = 8;
  localparam int F          = 4;
  localparam int TOTAL      = (NI + 2) * F;
  localparam int WGT_ADDR_W = $clog2(TOTAL + 1);
  localparam int STEP_LIMIT = 400;

  // Expected result of one vector
  typedef struct packed {
    acc_t [F-1:0] wh;
    score_t       e_src;
    score_t       e_dst;
  } exp_t;

  logic                  clk;
  logic                  rst_n;
  logic                  load_en;
  logic [WGT_ADDR_W-1:0] wgt_addr;
  data_t                 wgt_dout;
  logic                  weights_loaded;
  logic                  feat_valid;
  feat_beat_t            feat;
  logic                  out_valid;
  score_pair_t           scores;
  acc_t [F-1:0]          wh_out;

  data_t  wmem [TOTAL];
  exp_t   exp_q [$];
  exp_t   exp_cur;
  int     pending = 0;
  string  test_name = "reset";
  int     err_cnt = 0;
  int     timeouts = 0;
  int     err_base = 0;
  int     to_base = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  bit     ok;

  gat_wh_top #(
    .NUM_FEATURE_IN  (NI),
    .NUM_FEATURE_OUT (F)
  ) i_gat_wh_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_en        (load_en),
    .wgt_addr       (wgt_addr),
    .wgt_dout       (wgt_dout),
    .weights_loaded (weights_loaded),
    .feat_valid     (feat_valid),
    .feat           (feat),
    .out_valid      (out_valid),
    .scores         (scores),
    .wh_out         (wh_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Registered read of the weight memory
  // Addresses past the end read as zero
  always @(posedge clk) begin
    wgt_dout = #2 (wgt_addr < TOTAL) ? wmem[wgt_addr] : data_t'(0);
  end

  // Retire one expected vector per output pulse
  always @(posedge clk) begin
    if (out_valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      if (exp_q.size() > 0) begin
        exp_cur = exp_q[0];
      end
      pending = exp_q.size();
    end
  end

  // ==========================================================================
  // Reporting
  // ==========================================================================
  task automatic report_value(input string what, input logic [127:0] exp_v,
                              input logic [127:0] act_v);
    err_cnt++;
    $display("Fail %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
  endtask

  task automatic report_event(input string msg);
    err_cnt++;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = err_cnt;
    to_base   = timeouts;
  endtask

  task automatic end_test();
    int bad;
    bad = (err_cnt - err_base) + (timeouts - to_base);
    tests_run++;
    if (bad == 0) begin
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d problems", test_name, bad);
    end
  endtask

  // ==========================================================================
  // Checks
  // ==========================================================================
  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> (wgt_addr == '0 && !weights_loaded && !out_valid))
    else report_event("outputs not idle after reset");

  a_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (load_en && wgt_addr < TOTAL) |=> (wgt_addr == $past(wgt_addr) + 1))
    else report_event("wgt_addr did not advance after an accepted address");

  a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_en && wgt_addr < TOTAL) |=> $stable(wgt_addr))
    else report_event("wgt_addr moved without an accepted address");

  // Registered at the second edge after the last accepted address
  a_load_done: assert property (@(posedge clk) disable iff (!rst_n)
    (load_en && wgt_addr == TOTAL - 1) |-> ##3 $rose(weights_loaded))
    else report_event("weights_loaded did not rise 2 cycles after the last address");

  a_load_early: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(weights_loaded) |-> $past(load_en && wgt_addr == TOTAL - 1, 3))
    else report_event("weights_loaded rose at the wrong time");

  a_load_hold: assert property (@(posedge clk) disable iff (!rst_n)
    weights_loaded |=> weights_loaded)
    else report_event("weights_loaded dropped before reset");

  // out_valid is registered at the third edge after the last beat
  a_out_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (feat_valid && feat.last) |-> ##4 out_valid)
    else report_event("out_valid missing 3 cycles after the last beat");

  a_out_source: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (pending > 0 && $past(feat_valid && feat.last, 4)))
    else report_event("out_valid without a matching vector");

  a_wh: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (wh_out == exp_cur.wh))
    else report_value("wh_out", $sampled(exp_cur.wh), $sampled(wh_out));

  a_src: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (scores.e_src == exp_cur.e_src))
    else report_value("e_src", $sampled(exp_cur.e_src), $sampled(scores.e_src));

  a_dst: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (scores.e_dst == exp_cur.e_dst))
    else report_value("e_dst", $sampled(exp_cur.e_dst), $sampled(scores.e_dst));

  // ==========================================================================
  // Reference model and stimulus
  // ==========================================================================
  function automatic exp_t compute_expected(input int vals[NI]);
    exp_t   e;
    longint sum;
    longint src;
    longint dst;
    src = 0;
    dst = 0;
    for (int c = 0; c < F; c++) begin
      sum = 0;
      for (int r = 0; r < NI; r++) begin
        sum += longint'(vals[r]) * longint'(wmem[r * F + c]);
      end
      e.wh[c] = acc_t'(sum);
      src += longint'(wmem[NI * F + c]) * sum;
      dst += longint'(wmem[NI * F + F + c]) * sum;
    end
    e.e_src = score_t'(src);
    e.e_dst = score_t'(dst);
    return e;
  endfunction

  task automatic push_expected(input exp_t e);
    exp_q.push_back(e);
    if (exp_q.size() == 1) begin
      exp_cur = e;
    end
    pending = exp_q.size();
  endtask

  // Leaves feat_valid high after the last beat for back-to-back vectors
  task automatic send_vector(input int gap_max);
    int   vals[NI];
    int   gaps;
    exp_t e;
    for (int r = 0; r < NI; r++) begin
      vals[r] = int'(data_t'($urandom()));
    end
    e = compute_expected(vals);
    for (int r = 0; r < NI; r++) begin
      gaps = (gap_max > 0) ? $urandom_range(gap_max, 0) : 0;
      if (gaps > 0) begin
        feat_valid = 1'b0;
        repeat (gaps) @(posedge clk);
        #2;
      end
      feat_valid = 1'b1;
      feat.value = data_t'(vals[r]);
      feat.last  = (r == NI - 1);
      if (r == NI - 1) begin
        push_expected(e);
      end
      @(posedge clk);
      #2;
    end
  endtask

  // Enable stays up once the end is reached so the address has to hold
  task automatic run_load(output bit done);
    int cycles;
    cycles = 0;
    while (!weights_loaded && cycles < STEP_LIMIT) begin
      load_en = ($urandom_range(3, 0) != 0) || (wgt_addr == TOTAL);
      @(posedge clk);
      #2;
      cycles++;
    end
    load_en = 1'b0;
    done = weights_loaded;
  endtask

  task automatic drain(output bit done);
    int cycles;
    feat_valid = 1'b0;
    cycles = 0;
    while (pending > 0 && cycles < STEP_LIMIT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    done = (pending == 0);
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("%s: timed out waiting for %s", test_name, what);
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    rst_n      = 1'b0;
    load_en    = 1'b0;
    feat_valid = 1'b0;
    feat       = '0;
    wgt_dout   = '0;
    void'($urandom(32'hb7a5_74ee));
    for (int i = 0; i < TOTAL; i++) begin
      wmem[i] = data_t'($urandom());
    end
    start_test("load");
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    run_load(ok);
    if (!ok) note_timeout("weights_loaded");
    end_test();

    start_test("single_vector");
    send_vector(0);
    drain(ok);
    if (!ok) note_timeout("the result");
    end_test();

    start_test("back_to_back");
    repeat (4) send_vector(0);
    drain(ok);
    if (!ok) note_timeout("all results");
    end_test();

    start_test("random_gaps");
    repeat (6) send_vector(3);
    drain(ok);
    if (!ok) note_timeout("all results");
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, err_cnt, timeouts);
    if (tests_failed == 0 && err_cnt == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/gat_pkg.sv
rtl/bram.sv
rtl/w_loader.sv
rtl/wh_engine.sv
rtl/attn_score.sv
rtl/gat_wh_top.sv
tb/tb_gat_wh.sv

//--- Bender.yml
package:
  name: gat_wh

sources:
  - rtl/gat_pkg.sv
  - rtl/bram.sv
  - rtl/w_loader.sv
  - rtl/wh_engine.sv
  - rtl/attn_score.sv
  - rtl/gat_wh_top.sv
  - target: test
    files:
      - tb/tb_gat_wh.sv
